// File: audio_top.f
+incdir+logic
logic/psg_pkg.sv
logic/mix_pkg.sv
logic/sample_mixer.sv
logic/dac_channel.sv
logic/audio_top.sv
bench/audio_top_checker.sv
bench/audio_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds and runs the audio path regression with Verilator
# run from anywhere, paths are taken relative to this script

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f audio_top.f \
	--top-module audio_top_tb \
	-o audio_top_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

if [ ! -x obj_dir/audio_top_sim ]; then
	echo "simulation binary missing after build"
	exit 1
fi

# keep running past assertion errors so the testbench reports them
out=$(./obj_dir/audio_top_sim +verilator+error+limit+1000 2>&1)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Regression passed"; then
	exit 0
fi

echo "pass line not found in simulation output"
exit 1

// File: bench/audio_top_tb.sv
// ######################################
// table driven run of the audio path
// densities counted over 4096 cycles within one count
// inputs driven on the falling edge
// ######################################

`timescale 1ns/1ps

`include "audio_cfg.svh"

module audio_top_tb
	import psg_pkg::*, mix_pkg::*;
();

	localparam int PERIOD  = 20;
	localparam int RST_CYC = 10;
	localparam int SETTLE  = 8;     // strobe to stable bitstream plus margin
	localparam int WIN     = 4096;  // counting window
	localparam int N_ENT   = 10;
	localparam int MIX_W   = `AUDIO_MIX_W;
	localparam int SUM_W   = `AUDIO_SUM_W;
	localparam int DMA_W   = `AUDIO_DMA_W;
	localparam int FULL    = 1 << MIX_W;
	localparam int HALF    = 1 << (MIX_W - 1); // offset binary midpoint
	localparam int PSG_SH  = MIX_W - SUM_W - 1; // psg fill bits
	localparam int DMA_SH  = MIX_W - DMA_W - 1; // dma fill bits
	localparam logic [31:0] SEED = 32'd19899;

	// one row of stimulus
	typedef struct packed {
		psg_mode_e   mode;
		psg_sample_t psg;
		dma_sample_t dma;
		logic        psg_fire;
		logic        dma_fire;
	} stim_t;

	string name_tb [N_ENT];
	stim_t stim_tb [N_ENT];
	int    exp_l_tb [N_ENT]; // expected ones per window
	int    exp_r_tb [N_ENT];

	logic        clk_32;
	logic        xsint;
	logic        psg_stb_i;
	logic        dma_stb_i;
	psg_sample_t psg_sample_i;
	dma_sample_t dma_sample_i;
	psg_mode_e   psg_mode_i;
	logic        audio_l_o;
	logic        audio_r_o;

	logic [31:0] rng;
	int          errors;
	int          checks;

	audio_top u_dut (
		.clk_32       ( clk_32       ),
		.xsint        ( xsint        ),
		.psg_stb_i    ( psg_stb_i    ),
		.psg_sample_i ( psg_sample_i ),
		.psg_mode_i   ( psg_mode_i   ),
		.dma_stb_i    ( dma_stb_i    ),
		.dma_sample_i ( dma_sample_i ),
		.audio_l_o    ( audio_l_o    ),
		.audio_r_o    ( audio_r_o    )
	);

	initial begin
		clk_32 = 1'b0;
		forever #(PERIOD / 2) clk_32 = ~clk_32;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [7:0] rand_byte();
		rng = xorshift(rng);
		return rng[15:8];
	endfunction

	// u of one side from the signed psg and dma values
	// scaled to 15 bits with msbs repeated as fill
	// and the midpoint added back
	function automatic int density_u(input int psg_sum, input int dma_byte);
		int sp;
		int sd;
		int m;
		sp = psg_sum - `AUDIO_PSG_OFS;   // -512..253
		sd = dma_byte - `AUDIO_DMA_OFS;  // -128..127
		m = sp * (1 << PSG_SH) + ((sp & ((1 << SUM_W) - 1)) >> (SUM_W - PSG_SH));
		m = m + sd * (1 << DMA_SH) + ((sd & ((1 << DMA_W) - 1)) >> (DMA_W - DMA_SH));
		return (((m + HALF) % FULL) + FULL) % FULL; // top bit flip with wrap
	endfunction

	task automatic report_end();
		int asrt;
		asrt = u_dut.u_checker.fail_rst + u_dut.u_checker.fail_mix + u_dut.u_checker.fail_x;
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors, asrt);
		if (errors == 0 && asrt == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	endtask

	task automatic stall(input string what);
		errors++;
		$display("clock stalled while waiting for %s", what);
		report_end();
	endtask

	task automatic compare(input string what, input int expected, input int actual,
			input int tol);
		int diff;
		diff = expected - actual;
		if (diff < 0)
			diff = -diff;
		checks++;
		if (diff > tol) begin
			errors++;
			$display("[ERROR] %s expected %0d actual %0d", what, expected, actual);
		end
	endtask

	// one falling edge or a stall report after two periods
	task automatic next_negedge(input string what);
		time t0;
		t0 = $time;
		fork
			@(negedge clk_32);
			#(2 * PERIOD);
		join_any
		disable fork;
		if ($time - t0 >= 2 * PERIOD)
			stall(what);
	endtask

	task automatic step_cycles(input int n, input string what);
		int k;
		for (k = 0; k < n; k++)
			next_negedge(what);
	endtask

	// ones sampled on falling edges where the bits are stable
	task automatic count_ones(input int n, output int ones_l, output int ones_r);
		int k;
		ones_l = 0;
		ones_r = 0;
		for (k = 0; k < n; k++) begin
			next_negedge("the bitstream count window");
			ones_l += int'(audio_l_o);
			ones_r += int'(audio_r_o);
		end
	endtask

	task automatic set_entry(input int i, input string nm, input psg_mode_e md,
			input psg_sample_t p, input dma_sample_t d, input logic pf, input logic df);
		name_tb[i] = nm;
		stim_tb[i] = '{mode: md, psg: p, dma: d, psg_fire: pf, dma_fire: df};
	endtask

	task automatic fill_table();
		set_entry(0, "reset_idle", PSG_MONO, '0, {8'd128, 8'd128}, 1'b0, 1'b0);
		set_entry(1, "mono_fixed", PSG_MONO, {8'd40, 8'd80, 8'd120}, {8'd128, 8'd128},
			1'b1, 1'b0);
		set_entry(2, "mono_random", PSG_MONO, {rand_byte(), rand_byte(), rand_byte()},
			{rand_byte(), rand_byte()}, 1'b1, 1'b0);
		set_entry(3, "stereo_abc", PSG_STEREO, {8'd10, 8'd100, 8'd220}, {8'd128, 8'd128},
			1'b1, 1'b0);
		set_entry(4, "dma_alone", PSG_STEREO, {rand_byte(), rand_byte(), rand_byte()},
			{8'd200, 8'd30}, 1'b0, 1'b1);                  // junk on psg inputs without strobe
		set_entry(5, "dma_random", PSG_STEREO, {rand_byte(), rand_byte(), rand_byte()},
			{rand_byte(), rand_byte()}, 1'b0, 1'b1);
		set_entry(6, "hold_inputs", PSG_STEREO, {rand_byte(), rand_byte(), rand_byte()},
			{rand_byte(), rand_byte()}, 1'b0, 1'b0);
		set_entry(7, "mode_to_mono", PSG_MONO, {rand_byte(), rand_byte(), rand_byte()},
			{rand_byte(), rand_byte()}, 1'b0, 1'b0);       // reload from mode only
		set_entry(8, "both_strobes", PSG_MONO, {rand_byte(), rand_byte(), rand_byte()},
			{rand_byte(), rand_byte()}, 1'b1, 1'b1);
		set_entry(9, "stereo_edges", PSG_STEREO, {8'd255, 8'd1, 8'd0}, {8'd0, 8'd255},
			1'b1, 1'b1);
	endtask

	// walks the table like the hardware with held samples and reloads on strobe or mode
	task automatic build_expected();
		psg_sample_t hp;
		dma_sample_t hd;
		psg_mode_e   last_mode;
		logic        live;
		int          i;
		int          a;
		int          b;
		int          c;
		int          u_l;
		int          u_r;
		hp = '0;
		hd = {8'(`AUDIO_DMA_OFS), 8'(`AUDIO_DMA_OFS)};
		last_mode = stim_tb[0].mode; // mode driven through reset
		live = 1'b0;                 // mix word still 0 from reset
		for (i = 0; i < N_ENT; i++) begin
			if (stim_tb[i].psg_fire)
				hp = stim_tb[i].psg;
			if (stim_tb[i].dma_fire)
				hd = stim_tb[i].dma;
			if (stim_tb[i].psg_fire || stim_tb[i].dma_fire || stim_tb[i].mode != last_mode)
				live = 1'b1;
			last_mode = stim_tb[i].mode;
			a = int'(hp.ch_a);
			b = int'(hp.ch_b);
			c = int'(hp.ch_c);
			if (!live) begin
				u_l = HALF;
				u_r = HALF;
			end else if (stim_tb[i].mode == PSG_STEREO) begin
				u_l = density_u(a + b, int'(hd.left));
				u_r = density_u(c + b, int'(hd.right));
			end else begin
				u_l = density_u(a + b + c, int'(hd.left));
				u_r = density_u(a + b + c, int'(hd.right));
			end
			exp_l_tb[i] = WIN * u_l / FULL;
			exp_r_tb[i] = WIN * u_r / FULL;
		end
	endtask

	task automatic apply_entry(input int i);
		int cnt_l;
		int cnt_r;
		psg_mode_i   = stim_tb[i].mode;
		psg_sample_i = stim_tb[i].psg;
		dma_sample_i = stim_tb[i].dma;
		psg_stb_i    = stim_tb[i].psg_fire;
		dma_stb_i    = stim_tb[i].dma_fire;
		step_cycles(1, "the strobe cycle");
		psg_stb_i = 1'b0;
		dma_stb_i = 1'b0; // samples stay on the inputs
		step_cycles(SETTLE, "the mixer and dac to settle");
		count_ones(WIN, cnt_l, cnt_r);
		compare({name_tb[i], "_left"}, exp_l_tb[i], cnt_l, 1);
		compare({name_tb[i], "_right"}, exp_r_tb[i], cnt_r, 1);
	endtask

	initial begin
		int i;
		errors = 0;
		checks = 0;
		rng = SEED;
		xsint = 1'b0;
		psg_stb_i = 1'b0;
		dma_stb_i = 1'b0;
		psg_sample_i = '0;
		dma_sample_i = '0;
		psg_mode_i = PSG_MONO;
		fill_table();
		build_expected();
		psg_mode_i = stim_tb[0].mode;

		// bitstreams low all through reset
		for (i = 0; i < RST_CYC; i++) begin
			step_cycles(1, "a reset cycle");
			compare("reset_left", 0, int'(audio_l_o), 0);
			compare("reset_right", 0, int'(audio_r_o), 0);
		end
		xsint = 1'b1; // released on a falling edge
		step_cycles(1, "the first cycle after reset");
		compare("after_reset_left", 0, int'(audio_l_o), 0);
		compare("after_reset_right", 0, int'(audio_r_o), 0);

		for (i = 0; i < N_ENT; i++)
			apply_entry(i);

		report_end();
	end

endmodule

// File: bench/audio_top_checker.sv
// ######################################
// bound into audio_top, watches reset, mix
// reload timing and unknown outputs
// failure counters are read by the testbench
// ######################################

`timescale 1ns/1ps

module audio_top_checker
	import psg_pkg::*, mix_pkg::*;
(
	input logic        clk_32,
	input logic        xsint,
	input logic        psg_stb_i,
	input logic        dma_stb_i,
	input psg_mode_e   psg_mode_i,
	input mix_sample_t mix_i,      // mixer output word
	input logic        bit_l_i,    // left bitstream
	input logic        bit_r_i     // right bitstream
);

	int fail_rst = 0; // reset level violations
	int fail_mix = 0; // unexpected mix reloads
	int fail_x   = 0; // unknown bitstream bits

	// both bitstreams held low in reset
	a_rst_low: assert property (@(posedge clk_32) !xsint |-> (!bit_l_i && !bit_r_i))
		else begin
			$error("bitstream high while xsint is low");
			fail_rst++;
		end

	// strobe at t -> upd_q -> mix reload at t+1, seen here at t+2
	// mode change reloads one edge earlier
	a_mix_upd: assert property (@(posedge clk_32) disable iff (!xsint)
		(mix_i != $past(mix_i)) |->
		($past(psg_stb_i || dma_stb_i, 2) || ($past(psg_mode_i) != $past(psg_mode_i, 2))))
		else begin
			$error("mix word changed without a strobe or mode change");
			fail_mix++;
		end

	a_no_x: assert property (@(posedge clk_32) disable iff (!xsint)
		!$isunknown({bit_l_i, bit_r_i}))
		else begin
			$error("bitstream unknown after reset");
			fail_x++;
		end

endmodule

bind audio_top audio_top_checker u_checker (
	.clk_32     ( clk_32     ),
	.xsint      ( xsint      ),
	.psg_stb_i  ( psg_stb_i  ),
	.dma_stb_i  ( dma_stb_i  ),
	.psg_mode_i ( psg_mode_i ),
	.mix_i      ( mix        ),
	.bit_l_i    ( audio_l_o  ),
	.bit_r_i    ( audio_r_o  )
);

// File: logic/audio_top.sv
// ######################################
// audio output path, psg plus dma sound
// to two sigma-delta bitstreams
// strobe edge to first new bitstream bit is 3 edges
// outputs want an external rc low pass
// ######################################

`timescale 1ns/1ps

module audio_top
	import psg_pkg::*, mix_pkg::*;
(
	input  logic        clk_32,
	input  logic        xsint,        // async, active low
	// psg side
	input  logic        psg_stb_i,    // one cycle per new sample
	input  psg_sample_t psg_sample_i,
	input  psg_mode_e   psg_mode_i,   // mono or stereo routing
	// dma sound side
	input  logic        dma_stb_i,    // one cycle per new sample
	input  dma_sample_t dma_sample_i,
	// bitstreams
	output logic        audio_l_o,
	output logic        audio_r_o
);

	mix_sample_t mix; // blended word per side

	// capture and blend, two stages
	sample_mixer u_mixer (
		.clk_32       ( clk_32       ),
		.xsint        ( xsint        ),
		.psg_stb_i    ( psg_stb_i    ),
		.psg_sample_i ( psg_sample_i ),
		.dma_stb_i    ( dma_stb_i    ),
		.dma_sample_i ( dma_sample_i ),
		.psg_mode_i   ( psg_mode_i   ),
		.mix_o        ( mix          )
	);

	// left bitstream
	dac_channel u_dac_l (
		.clk_32  ( clk_32    ),
		.xsint   ( xsint     ),
		.level_i ( mix.left  ),
		.bit_o   ( audio_l_o )
	);

	// right bitstream
	dac_channel u_dac_r (
		.clk_32  ( clk_32    ),
		.xsint   ( xsint     ),
		.level_i ( mix.right ),
		.bit_o   ( audio_r_o )
	);

endmodule

// File: logic/dac_channel.sv
// ######################################
// first order sigma-delta, one bit out
// density of ones is (level + 16384) / 32768
// output bit lags the input by one edge
// ######################################

`timescale 1ns/1ps

`include "audio_cfg.svh"

module dac_channel (
	input  logic                           clk_32,
	input  logic                           xsint,   // async, active low
	input  logic signed [`AUDIO_MIX_W-1:0] level_i, // two's complement
	output logic                           bit_o    // bitstream
);

	localparam int MIX_W = `AUDIO_MIX_W;

	logic [MIX_W-1:0] ofs;   // level in offset binary
	logic [MIX_W:0]   sum;   // carry on top
	logic [MIX_W-1:0] acc_q; // error accumulator
	logic             bit_q;

	// flipping the sign bit maps -16384..16383 to 0..32767
	assign ofs = {~level_i[MIX_W-1], level_i[MIX_W-2:0]};

	assign sum = {1'b0, acc_q} + {1'b0, ofs};

	// carry out is the pulse, remainder stays in acc
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			acc_q <= '0;
			bit_q <= 1'b0;
		end else begin
			acc_q <= sum[MIX_W-1:0];
			bit_q <= sum[MIX_W]; // never set on the first edge, acc starts at 0
		end
	end

	assign bit_o = bit_q;

endmodule

// File: logic/sample_mixer.sv
// ######################################
// holds psg and dma samples taken on strobes
// and blends them into one 15 bit word per side
// mix reloads only on the edge after a strobe or
// a mode change, so it stays 0 until the first strobe
// ######################################

`timescale 1ns/1ps

`include "audio_cfg.svh"

module sample_mixer
	import psg_pkg::*, mix_pkg::*;
(
	input  logic        clk_32,
	input  logic        xsint,        // async, active low
	input  logic        psg_stb_i,    // one cycle, sample valid
	input  psg_sample_t psg_sample_i,
	input  logic        dma_stb_i,    // one cycle, sample valid
	input  dma_sample_t dma_sample_i,
	input  psg_mode_e   psg_mode_i,   // level
	output mix_sample_t mix_o
);

	localparam int PSG_W   = `AUDIO_PSG_W;
	localparam int SUM_W   = `AUDIO_SUM_W;
	localparam int DMA_W   = `AUDIO_DMA_W;
	localparam int MIX_W   = `AUDIO_MIX_W;
	localparam int PSG_OFS = `AUDIO_PSG_OFS;
	localparam int DMA_OFS = `AUDIO_DMA_OFS;
	localparam int PSG_LO  = MIX_W - SUM_W - 1; // low fill bits of psg term
	localparam int DMA_LO  = MIX_W - DMA_W - 1; // low fill bits of dma term

	// signed 10 bit psg value to 15 bits
	// sign once more on top, own msbs repeated below
	// so full scale lands close to full scale
	function automatic logic [MIX_W-1:0] psg_term(input logic [SUM_W-1:0] s);
		psg_term = {s[SUM_W-1], s, s[SUM_W-1 -: PSG_LO]};
	endfunction

	// same idea for the signed dma byte
	function automatic logic [MIX_W-1:0] dma_term(input logic [DMA_W-1:0] s);
		dma_term = {s[DMA_W-1], s, s[DMA_W-1 -: DMA_LO]};
	endfunction

	psg_sample_t psg_q;   // held psg sample
	dma_sample_t dma_q;   // held dma sample
	psg_mode_e   mode_d;  // mode seen on the last edge
	logic        upd_q;   // a strobe landed on the last edge
	logic        mode_chg;
	mix_sample_t mix_q;
	mix_sample_t mix_d;

	logic [SUM_W-1:0] ch_a, ch_b, ch_c;        // zero extended channels
	logic [SUM_W-1:0] sum_ab, sum_cb, sum_abc;
	logic [SUM_W-1:0] psg_l, psg_r;            // routed sums, unsigned
	logic [SUM_W-1:0] psg_l_s, psg_r_s;        // after midpoint removal
	logic [DMA_W-1:0] dma_l_s, dma_r_s;

	// sample capture, payload registers
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			psg_q <= '0; // all channels silent
			dma_q <= '{left: DMA_W'(DMA_OFS), right: DMA_W'(DMA_OFS)};
		end else begin
			if (psg_stb_i)
				psg_q <= psg_sample_i;
			if (dma_stb_i)
				dma_q <= dma_sample_i;
		end
	end

	// follows the mode input every edge, reset included
	// so a mode held through reset is not a change
	always_ff @(posedge clk_32) begin
		mode_d <= psg_mode_i;
	end

	assign mode_chg = (psg_mode_i != mode_d);

	// channel sums, no overflow at 10 bits
	assign ch_a = SUM_W'(psg_q.ch_a);
	assign ch_b = SUM_W'(psg_q.ch_b);
	assign ch_c = SUM_W'(psg_q.ch_c);

	assign sum_ab  = ch_a + ch_b;
	assign sum_cb  = ch_c + ch_b;
	assign sum_abc = ch_a + ch_b + ch_c;

	always_comb begin
		if (psg_mode_i == PSG_STEREO) begin
			psg_l = sum_ab;
			psg_r = sum_cb;
		end else begin
			psg_l = sum_abc; // mono, same on both sides
			psg_r = sum_abc;
		end
	end

	// to two's complement, wraps on purpose
	assign psg_l_s = psg_l - SUM_W'(PSG_OFS);
	assign psg_r_s = psg_r - SUM_W'(PSG_OFS);
	assign dma_l_s = dma_q.left - DMA_W'(DMA_OFS);
	assign dma_r_s = dma_q.right - DMA_W'(DMA_OFS);

	// 15 bit wrap around blend per side
	assign mix_d.left  = psg_term(psg_l_s) + dma_term(dma_l_s);
	assign mix_d.right = psg_term(psg_r_s) + dma_term(dma_r_s);

	// blend stage
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			upd_q <= 1'b0;
			mix_q <= '0;
		end else begin
			upd_q <= psg_stb_i | dma_stb_i;
			if (upd_q || mode_chg)
				mix_q <= mix_d; // held values are settled here
		end
	end

	assign mix_o = mix_q;

	// psg channel width only matters through the sum width
	initial begin
		if (SUM_W < PSG_W + 2)
			$error("psg sum too narrow for three channels");
	end

endmodule

// File: logic/mix_pkg.sv
// ######################################
// dma sound and blended sample types
// dma bytes are offset binary, mix is signed
// ######################################

`include "audio_cfg.svh"

package mix_pkg;

	// dma sound pair as delivered with dma_stb_i
	// 0x80 on a side means silence
	typedef struct packed {
		logic [`AUDIO_DMA_W-1:0] left;  // upper byte
		logic [`AUDIO_DMA_W-1:0] right; // lower byte
	} dma_sample_t;

	// blended output of the mixer, one word per side
	// each field is two's complement
	// top bit of each field is the sign
	typedef struct packed {
		logic [`AUDIO_MIX_W-1:0] left;  // to left dac
		logic [`AUDIO_MIX_W-1:0] right; // to right dac
	} mix_sample_t;

endpackage

// File: logic/psg_pkg.sv
// ######################################
// psg side types of the audio path
// channels are unsigned levels, 0 is silent
// ######################################

`include "audio_cfg.svh"

package psg_pkg;

	// one psg sample as delivered with psg_stb_i
	// ch_a sits in the top byte
	typedef struct packed {
		logic [`AUDIO_PSG_W-1:0] ch_a; // channel a
		logic [`AUDIO_PSG_W-1:0] ch_b; // channel b, shared by both sides
		logic [`AUDIO_PSG_W-1:0] ch_c; // channel c
	} psg_sample_t;

	// channel routing
	// mono puts a+b+c on both sides
	// stereo puts a+b left and c+b right
	typedef enum logic {
		PSG_MONO   = 1'b0,
		PSG_STEREO = 1'b1
	} psg_mode_e;

endpackage

// File: logic/audio_cfg.svh
// ######################################
// sample widths and midpoints of the audio path
// the blend layout in the mixer assumes MIX_W is
// larger than both SUM_W and DMA_W plus one
// ######################################

`ifndef AUDIO_CFG_SVH
`define AUDIO_CFG_SVH

// one psg channel, unsigned level
`define AUDIO_PSG_W 8

// sum of up to three psg channels
// 3 x 255 still fits in 10 bits
`define AUDIO_SUM_W 10

// one dma sound byte, offset binary
`define AUDIO_DMA_W 8

// blended sample per side, two's complement
`define AUDIO_MIX_W 15

// psg sum midpoint
// subtracted to get a signed value
`define AUDIO_PSG_OFS 512

// dma byte midpoint, 0x80 is silence
`define AUDIO_DMA_OFS 128

`endif
